// File: Makefile
# Verilator build and run for the sprite engine testbench

VERILATOR ?= verilator
TOP       ?= obj_engine_tb
BUILD     ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD) -o $(TOP)

# Passes only when the pass message is found in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: bench/obj_engine_tb.sv
// Testbench for the sprite engine, runs CPU, render and overlap tests against a reference line
`timescale 1ns/10ps

module obj_engine_tb;
    import obj_pkg::*;

    localparam int LINE_CYC  = 600;
    localparam int NUM_LINES = 12;
    localparam int MARGIN    = 2000;
    localparam int LIMIT     = NUM_LINES * LINE_CYC + MARGIN;

    logic              clk = 1'b0;
    logic              rst;
    logic              cpu_cs;
    logic              cpu_we;
    logic [RAM_AW-1:0] cpu_addr;
    logic [7:0]        cpu_din;
    logic [7:0]        cpu_dout;
    logic              cpu_ack;
    logic              hinit;
    logic [7:0]        vrender;
    logic [7:0]        hdump;
    rom_req_t          rom_q;
    logic [ROM_DW-1:0] rom_data;
    logic              rom_ok;
    logic [3:0]        pxl;

    // Table mirror, graphics content and reference lines
    logic [7:0]        tbl [0:OBJ_COUNT*OBJ_BYTES-1];
    logic [ROM_DW-1:0] gfx [0:(1<<ROM_AW)-1];
    logic [3:0]        pend [0:LINE_W-1];
    logic [3:0]        exp_line [0:LINE_W-1];
    bit                pend_ok = 1'b0;
    string             pend_name = "none";
    logic [15:0]       lfsr = 16'(88252);
    int                errors = 0;
    int                cycles = 0;

    obj_engine_top i_obj_engine_top (
        .clk      (clk),
        .rst      (rst),
        .cpu_cs   (cpu_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_dout (cpu_dout),
        .cpu_ack  (cpu_ack),
        .hinit    (hinit),
        .vrender  (vrender),
        .hdump    (hdump),
        .rom      (rom_q),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pxl      (pxl)
    );

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout reached after %0d cycles, errors so far %0d", cycles, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // ROM model, latency 0 to 7 cycles per request
    always begin
        int lat;
        @(posedge clk);
        #1;
        rom_ok = 1'b0;
        if (rom_q.cs === 1'b1) begin
            lat = int'(rand_bits(3));
            repeat (lat) begin
                @(posedge clk);
                #1;
            end
            rom_data = gfx[rom_q.addr];
            rom_ok   = 1'b1;
        end
    end

    // Reference for the line after vline, lower index drawn first and only onto transparent pixels
    task automatic render(input logic [7:0] vline);
        logic [7:0]        d;
        logic [3:0]        row;
        logic [3:0]        src;
        logic [ROM_DW-1:0] w;
        logic [3:0]        nib;
        logic [7:0]        px;
        for (int x = 0; x < LINE_W; x++) begin
            pend[x] = 4'd0;
        end
        for (int i = 0; i < OBJ_COUNT; i++) begin
            d = vline - tbl[4*i];
            if (d < 8'(OBJ_SIZE)) begin
                row = tbl[4*i+3][7] ? 4'd15 - d[3:0] : d[3:0];
                for (int k = 0; k < OBJ_SIZE; k++) begin
                    src = tbl[4*i+3][6] ? 4'(15 - k) : 4'(k);
                    w   = gfx[{tbl[4*i+2], row, src[3]}];
                    nib = w[{src[2:0], 2'b00} +: 4];
                    px  = tbl[4*i+1] + 8'(k);
                    if (nib != 4'd0 && pend[px] == 4'd0) begin
                        pend[px] = nib;
                    end
                end
            end
        end
    endtask

    // Holds the request until ack, read data taken in the ack cycle
    task automatic cpu_access(input logic [6:0] a, input logic we, input logic [7:0] d,
                              output logic [7:0] q);
        int n;
        n        = 0;
        cpu_cs   = 1'b1;
        cpu_we   = we;
        cpu_addr = a;
        cpu_din  = d;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (cpu_ack !== 1'b1 && n < 100);
        if (cpu_ack !== 1'b1) begin
            errors++;
            $display("CPU request to address %0d was never acknowledged", a);
        end
        q      = cpu_dout;
        cpu_cs = 1'b0;
        if (we) begin
            tbl[a] = d;
        end
    endtask

    task automatic set_obj(input int i, input logic [7:0] y, input logic [7:0] x,
                           input logic [7:0] code, input logic [7:0] attr);
        logic [7:0] q;
        cpu_access(7'(4*i), 1'b1, y, q);
        cpu_access(7'(4*i+1), 1'b1, x, q);
        cpu_access(7'(4*i+2), 1'b1, code, q);
        cpu_access(7'(4*i+3), 1'b1, attr, q);
    endtask

    // One line period, compares the previous line while the next is drawn
    task automatic run_line(input logic [7:0] v, input bit chk_next, input string name);
        bit    chk;
        string cur_name;
        chk      = pend_ok;
        cur_name = pend_name;
        for (int x = 0; x < LINE_W; x++) begin
            exp_line[x] = pend[x];
        end
        render(v);
        pend_ok   = chk_next;
        pend_name = name;
        @(posedge clk);
        #1;
        hinit   = 1'b1;
        vrender = v;
        // Banks swap at the end of the hinit cycle, readout starts after it
        @(posedge clk);
        #1;
        hinit = 1'b0;
        hdump = 8'd0;
        for (int k = 0; k < LINE_W; k++) begin
            @(posedge clk);
            #1;
            if (chk) begin
                check($sformatf("%s x=%0d", cur_name, k), 32'(exp_line[k]), 32'(pxl));
            end
            if (k < LINE_W - 1) begin
                hdump = 8'(k + 1);
            end
        end
        repeat (LINE_CYC - LINE_W - 2) @(posedge clk);
        #1;
    endtask

    initial begin
        logic [7:0] q;
        rst      = 1'b1;
        cpu_cs   = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        hinit    = 1'b0;
        vrender  = '0;
        hdump    = '0;
        rom_data = '0;
        rom_ok   = 1'b0;
        for (int a = 0; a < (1 << ROM_AW); a++) begin
            gfx[a] = rand_bits(32);
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Byte pattern over every address, then read back
        for (int a = 0; a < 128; a++) begin
            cpu_access(7'(a), 1'b1, 8'((a * 37) ^ 8'hA5 ^ (a >> 5)), q);
        end
        for (int a = 0; a < 128; a++) begin
            cpu_access(7'(a), 1'b0, 8'd0, q);
            check("cpu_rw", 32'(8'((a * 37) ^ 8'hA5 ^ (a >> 5))), 32'(q));
        end
        for (int i = 0; i < OBJ_COUNT; i++) begin
            set_obj(i, 8'hC0, 8'd0, 8'd0, 8'd0);
        end

        // Clear the read bank before the first swap
        for (int k = 0; k < LINE_W; k++) begin
            @(posedge clk);
            #1;
            hdump = 8'(k);
        end
        run_line(8'd0, 1'b1, "empty");

        // Single sprite, edges of its zone
        set_obj(0, 8'd40, 8'd100, 8'd5, 8'h03);
        run_line(8'd39, 1'b1, "single_above");
        run_line(8'd40, 1'b1, "single_top");
        run_line(8'd55, 1'b1, "single_bottom");
        run_line(8'd56, 1'b1, "single_below");

        // Flip variants of one code
        set_obj(0, 8'd60, 8'd20, 8'd5, 8'h41);
        set_obj(1, 8'd60, 8'd80, 8'd5, 8'h82);
        set_obj(2, 8'd60, 8'd140, 8'd5, 8'hC3);
        set_obj(3, 8'd60, 8'd200, 8'd5, 8'h04);
        run_line(8'd63, 1'b1, "flip_row3");
        run_line(8'd71, 1'b1, "flip_row11");

        // Overlap, lower index on top
        set_obj(0, 8'd90, 8'd50, 8'd7, 8'h00);
        set_obj(1, 8'd90, 8'd58, 8'd9, 8'h00);
        set_obj(2, 8'd92, 8'd44, 8'd11, 8'h40);
        set_obj(3, 8'hC0, 8'd0, 8'd0, 8'h00);
        run_line(8'd95, 1'b1, "overlap");

        // Eight on one line, queue runs out of credits
        for (int i = 0; i < 8; i++) begin
            set_obj(i, 8'd120, 8'(i * 30 + 3), 8'(16 + i * 3), 8'(rand_bits(8)));
        end
        run_line(8'd125, 1'b1, "eight_sprites");

        // Writes while the table is being scanned
        fork
            run_line(8'd125, 1'b0, "during_write");
            begin
                repeat (5) @(posedge clk);
                #1;
                set_obj(3, 8'd118, 8'd210, 8'h21, 8'h80);
                set_obj(0, 8'hC0, 8'd0, 8'd0, 8'h00);
            end
        join
        run_line(8'd125, 1'b1, "after_write");
        run_line(8'd125, 1'b0, "flush");

        $display("Done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
src/obj_pkg.sv
src/obj_ram_arbiter.sv
src/obj_table_scan.sv
src/obj_draw.sv
src/obj_line_buffer.sv
src/obj_engine_top.sv
bench/obj_engine_tb.sv

// File: src/obj_draw.sv
// Sprite draw engine, queues commands, fetches ROM words and writes opaque pixels to the line buffer
`timescale 1ns/10ps

module obj_draw (
    input  logic                       clk,
    input  logic                       rst,
    input  obj_pkg::draw_cmd_t         cmd,
    input  logic                       cmd_valid,
    output logic                       credit_ret,
    // Graphics ROM
    output obj_pkg::rom_req_t          rom,
    input  logic [obj_pkg::ROM_DW-1:0] rom_data,
    input  logic                       rom_ok,
    // Line buffer
    output logic                       wr_en,
    output logic [7:0]                 wr_x,
    output logic [3:0]                 wr_pix,
    output logic                       busy
);
    import obj_pkg::*;

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_DRAW
    } draw_st_t;

    // Command queue, depth is a power of two so pointers wrap
    draw_cmd_t           queue [0:DRAW_DEPTH-1];
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic                pop;

    draw_st_t            state;
    draw_cmd_t           cur;
    logic                half;
    logic [2:0]          cnt;
    logic [ROM_DW-1:0]   word;
    logic                src_half;
    logic [2:0]          pix_idx;
    logic [3:0]          nib;

    assign pop = (state == D_IDLE) && (count != '0);

    // hflip fetches the right half first and reads each word backwards
    assign src_half = half ^ cur.hflip;
    assign pix_idx  = cur.hflip ? 3'd7 - cnt : cnt;
    assign nib      = word[{pix_idx, 2'b00} +: 4];

    // Word address is code*32 + row*2 + half
    assign rom.addr = ROM_AW'({cur.code, cur.row, src_half});
    assign rom.cs   = (state == D_FETCH);

    assign busy = (state != D_IDLE) || (count != '0) || wr_en;

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            queue[wr_ptr] <= cmd;
        end
    end

    // Queue pointers, count and credit return
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_ret <= pop;
        end
    end

    // Fetch and draw FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= D_IDLE;
            half  <= 1'b0;
            cnt   <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (pop) begin
                        half  <= 1'b0;
                        state <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    // Hold the request until the ROM answers
                    if (rom_ok) begin
                        cnt   <= '0;
                        state <= D_DRAW;
                    end
                end
                D_DRAW: begin
                    // Colour 0 is transparent, no write
                    wr_en <= (nib != 4'd0);
                    cnt   <= cnt + 3'd1;
                    if (cnt == 3'd7) begin
                        if (half) begin
                            state <= D_IDLE;
                        end else begin
                            half  <= 1'b1;
                            state <= D_FETCH;
                        end
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= queue[rd_ptr];
        end
        if (state == D_FETCH && rom_ok) begin
            word <= rom_data;
        end
        if (state == D_DRAW) begin
            // Screen position wraps at the line end
            wr_x   <= cur.xpos + {4'd0, half, cnt};
            wr_pix <= nib;
        end
    end

endmodule

// File: src/obj_engine_top.sv
// Sprite engine top level, ties the CPU, video, ROM and pixel ports to the four blocks
`timescale 1ns/10ps

module obj_engine_top (
    input  logic                       clk,
    input  logic                       rst,
    // CPU
    input  logic                       cpu_cs,
    input  logic                       cpu_we,
    input  logic [obj_pkg::RAM_AW-1:0] cpu_addr,
    input  logic [7:0]                 cpu_din,
    output logic [7:0]                 cpu_dout,
    output logic                       cpu_ack,
    // Video timing
    input  logic                       hinit,
    input  logic [7:0]                 vrender,
    input  logic [7:0]                 hdump,
    // Graphics ROM
    output obj_pkg::rom_req_t          rom,
    input  logic [obj_pkg::ROM_DW-1:0] rom_data,
    input  logic                       rom_ok,
    output logic [3:0]                 pxl
);
    import obj_pkg::*;

    logic              scan_req;
    logic [RAM_AW-2:0] scan_addr;
    logic              scan_gnt;
    logic [15:0]       scan_data;
    draw_cmd_t         cmd;
    logic              cmd_valid;
    logic              credit_ret;
    logic              wr_en;
    logic [7:0]        wr_x;
    logic [3:0]        wr_pix;

    obj_ram_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .cpu_cs    (cpu_cs),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .cpu_dout  (cpu_dout),
        .cpu_ack   (cpu_ack),
        .scan_req  (scan_req),
        .scan_addr (scan_addr),
        .scan_gnt  (scan_gnt),
        .scan_data (scan_data)
    );

    // Scanner prepares the line after vrender
    obj_table_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .line_start (hinit),
        .vline      (vrender),
        .ram_req    (scan_req),
        .ram_addr   (scan_addr),
        .ram_gnt    (scan_gnt),
        .ram_data   (scan_data),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .credit_ret (credit_ret)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .credit_ret (credit_ret),
        .rom        (rom),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_pix     (wr_pix),
        .busy       ()
    );

    obj_line_buffer u_lbuf (
        .clk        (clk),
        .rst        (rst),
        .line_start (hinit),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_pix     (wr_pix),
        .hdump      (hdump),
        .pxl        (pxl)
    );

endmodule

// File: src/obj_line_buffer.sv
// Double-banked line buffer, one bank drawn while the other plays out and is cleared
`timescale 1ns/10ps

module obj_line_buffer (
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    // Draw side
    input  logic       wr_en,
    input  logic [7:0] wr_x,
    input  logic [3:0] wr_pix,
    // Video side
    input  logic [7:0] hdump,
    output logic [3:0] pxl
);
    import obj_pkg::*;

    logic [3:0] mem [0:1][0:LINE_W-1];
    logic       sel;
    logic       rd_bank;

    // sel is the bank being drawn
    assign rd_bank = ~sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (line_start) begin
            sel <= ~sel;
        end
    end

    always_ff @(posedge clk) begin
        // First opaque write wins, lower index draws first
        if (wr_en && mem[sel][wr_x] == 4'd0) begin
            mem[sel][wr_x] <= wr_pix;
        end
        // Cleared behind the beam, ready for the next swap
        mem[rd_bank][hdump] <= 4'd0;
    end

    // Pixel out one cycle after hdump
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= 4'd0;
        end else begin
            pxl <= mem[rd_bank][hdump];
        end
    end

endmodule

// File: src/obj_pkg.sv
// Shared sizes and packed types for the sprite engine, imported by every RTL block
package obj_pkg;

    // Object table geometry
    localparam int OBJ_COUNT = 32;
    localparam int OBJ_BYTES = 4;
    localparam int RAM_AW    = 7;

    // Raster and sprite size
    localparam int LINE_W   = 256;
    localparam int OBJ_SIZE = 16;

    // Draw queue depth, also the credit count at reset
    localparam int DRAW_DEPTH = 2;
    localparam int CREDIT_W   = $clog2(DRAW_DEPTH + 1);
    localparam int QPTR_W     = $clog2(DRAW_DEPTH);

    // Graphics ROM, 8 pixels of 4 bits per word
    localparam int ROM_AW = 14;
    localparam int ROM_DW = 32;

    // Bit positions inside attr
    localparam int ATTR_VFLIP = 7;
    localparam int ATTR_HFLIP = 6;

    // One table entry, byte 0 is ypos
    typedef struct packed {
        logic [7:0] ypos;
        logic [7:0] xpos;
        logic [7:0] code;
        logic [7:0] attr;
    } obj_entry_t;

    // Scanner to draw engine
    typedef struct packed {
        logic [7:0] code;
        logic [7:0] xpos;
        logic [3:0] row;
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
    } draw_cmd_t;

    typedef struct packed {
        logic [ROM_AW-1:0] addr;
        logic              cs;
    } rom_req_t;

endpackage

// File: src/obj_ram_arbiter.sv
// Object table RAM shared by the CPU and the table scanner, scanner served first
`timescale 1ns/10ps

module obj_ram_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    // CPU byte port
    input  logic                      cpu_cs,
    input  logic                      cpu_we,
    input  logic [obj_pkg::RAM_AW-1:0] cpu_addr,
    input  logic [7:0]                cpu_din,
    output logic [7:0]                cpu_dout,
    output logic                      cpu_ack,
    // Scanner word port
    input  logic                      scan_req,
    input  logic [obj_pkg::RAM_AW-2:0] scan_addr,
    output logic                      scan_gnt,
    output logic [15:0]               scan_data
);
    import obj_pkg::*;

    // 64 words of 16 bits, low byte at even CPU address
    logic [15:0] mem [0:OBJ_COUNT*OBJ_BYTES/2-1];

    logic                cpu_gnt;
    logic [RAM_AW-2:0]   cpu_word;
    logic [15:0]         cpu_rd;

    // Scanner never waits
    assign scan_gnt = scan_req;

    // CPU only when the scanner is idle, and not again in its ack cycle
    assign cpu_gnt  = cpu_cs && !scan_req && !cpu_ack;
    assign cpu_word = cpu_addr[RAM_AW-1:1];
    assign cpu_rd   = mem[cpu_word];

    // Single port, one access per cycle
    always_ff @(posedge clk) begin
        if (scan_req) begin
            scan_data <= mem[scan_addr];
        end else if (cpu_gnt) begin
            if (cpu_we) begin
                // Byte write into one half of the word
                if (cpu_addr[0]) begin
                    mem[cpu_word][15:8] <= cpu_din;
                end else begin
                    mem[cpu_word][7:0] <= cpu_din;
                end
            end
            cpu_dout <= cpu_addr[0] ? cpu_rd[15:8] : cpu_rd[7:0];
        end
    end

    // Ack one cycle after the access, read data valid with it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_ack <= 1'b0;
        end else begin
            cpu_ack <= cpu_gnt;
        end
    end

endmodule

// File: src/obj_table_scan.sv
// Object table scanner, walks all entries at line start and sends in-zone sprites to the draw engine
`timescale 1ns/10ps

module obj_table_scan (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       line_start,
    input  logic [7:0]                 vline,
    // Object RAM
    output logic                       ram_req,
    output logic [obj_pkg::RAM_AW-2:0] ram_addr,
    input  logic                       ram_gnt,
    input  logic [15:0]                ram_data,
    // Draw commands, credit flow control
    output obj_pkg::draw_cmd_t         cmd,
    output logic                       cmd_valid,
    input  logic                       credit_ret
);
    import obj_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD0,
        S_RD1,
        S_WAIT,
        S_TEST
    } scan_st_t;

    scan_st_t            state;
    logic [4:0]          idx;
    logic [7:0]          line_y;
    obj_entry_t          entry;
    logic                rd_vld;
    logic                rd_word;
    logic [CREDIT_W-1:0] credit;
    logic [7:0]          ydiff;
    logic                inzone;
    logic                issue;

    // Two words per entry, word 0 then word 1
    assign ram_req  = (state == S_RD0) || (state == S_RD1);
    assign ram_addr = {idx, state == S_RD1};

    // Row inside the sprite, wraps at the bottom of the screen
    assign ydiff  = line_y - entry.ypos;
    assign inzone = ydiff < 8'(OBJ_SIZE);
    assign issue  = (state == S_TEST) && inzone && (credit != '0);

    // Read data returns one cycle after the grant
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_vld  <= 1'b0;
            rd_word <= 1'b0;
        end else begin
            rd_vld  <= ram_req && ram_gnt;
            rd_word <= ram_addr[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld) begin
            if (rd_word) begin
                entry.code <= ram_data[7:0];
                entry.attr <= ram_data[15:8];
            end else begin
                entry.ypos <= ram_data[7:0];
                entry.xpos <= ram_data[15:8];
            end
        end
    end

    // Scan FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= S_IDLE;
            idx    <= '0;
            line_y <= '0;
        end else if (line_start) begin
            // Zone tested on vline itself, so a sprite starts one line below its ypos
            state  <= S_RD0;
            idx    <= '0;
            line_y <= vline;
        end else begin
            case (state)
                S_RD0:   if (ram_gnt) state <= S_RD1;
                S_RD1:   if (ram_gnt) state <= S_WAIT;
                S_WAIT:  state <= S_TEST;
                S_TEST: begin
                    // Stall here while an in-zone sprite has no credit
                    if (!inzone || issue) begin
                        if (idx == 5'(OBJ_COUNT - 1)) begin
                            state <= S_IDLE;
                        end else begin
                            idx   <= idx + 5'd1;
                            state <= S_RD0;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Command register, one cycle pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cmd.code  <= entry.code;
            cmd.xpos  <= entry.xpos;
            cmd.row   <= ydiff[3:0] ^ {4{entry.attr[ATTR_VFLIP]}};
            cmd.pal   <= entry.attr[3:0];
            cmd.hflip <= entry.attr[ATTR_HFLIP];
            cmd.vflip <= entry.attr[ATTR_VFLIP];
        end
    end

    // Credits, one per free queue slot in the draw engine
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit <= CREDIT_W'(DRAW_DEPTH);
        end else begin
            case ({issue, credit_ret})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
        end
    end

endmodule
